// ==== Bender.yml ====
package:
  name: cpu_mem_subsystem

sources:
  - files:
      - design/axi_pkg.sv
      - design/axi_master_port.sv
      - design/axi_bus_arbiter.sv
      - design/axi_sram_slave.sv
      - design/cpu_mem_subsystem.sv
  - target: test
    files:
      - verification/tb_cpu_mem_subsystem.sv

// ==== design/axi_bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_bus_arbiter (
    input  logic             clk,
    input  logic             reset,
    // master 0
    input  axi_pkg::axi_ar_t m0_ar,
    input  logic             m0_ar_valid,
    output logic             m0_ar_ready,
    input  axi_pkg::axi_ar_t m0_aw,
    input  logic             m0_aw_valid,
    output logic             m0_aw_ready,
    input  axi_pkg::axi_w_t  m0_w,
    input  logic             m0_w_valid,
    output logic             m0_w_ready,
    output axi_pkg::axi_r_t  m0_r,
    output logic             m0_r_valid,
    input  logic             m0_r_ready,
    output axi_pkg::axi_b_t  m0_b,
    output logic             m0_b_valid,
    input  logic             m0_b_ready,
    // master 1
    input  axi_pkg::axi_ar_t m1_ar,
    input  logic             m1_ar_valid,
    output logic             m1_ar_ready,
    input  axi_pkg::axi_ar_t m1_aw,
    input  logic             m1_aw_valid,
    output logic             m1_aw_ready,
    input  axi_pkg::axi_w_t  m1_w,
    input  logic             m1_w_valid,
    output logic             m1_w_ready,
    output axi_pkg::axi_r_t  m1_r,
    output logic             m1_r_valid,
    input  logic             m1_r_ready,
    output axi_pkg::axi_b_t  m1_b,
    output logic             m1_b_valid,
    input  logic             m1_b_ready,
    // toward the slave
    output axi_pkg::axi_ar_t s_ar,
    output logic             s_ar_valid,
    input  logic             s_ar_ready,
    output axi_pkg::axi_ar_t s_aw,
    output logic             s_aw_valid,
    input  logic             s_aw_ready,
    output axi_pkg::axi_w_t  s_w,
    output logic             s_w_valid,
    input  logic             s_w_ready,
    input  axi_pkg::axi_r_t  s_r,
    input  logic             s_r_valid,
    output logic             s_r_ready,
    input  axi_pkg::axi_b_t  s_b,
    input  logic             s_b_valid,
    output logic             s_b_ready
);

    logic busy;
    logic grant;  // held grant, also the last winner
    logic req0;
    logic req1;
    logic pick;
    logic sel;

    assign req0 = m0_ar_valid | m0_aw_valid;
    assign req1 = m1_ar_valid | m1_aw_valid;

    always_comb begin
        if (req0 && req1)
            pick = ~grant;  // tie goes to last loser
        else
            pick = req1;
    end

    assign sel = busy ? grant : pick;

    assign s_ar       = sel ? m1_ar : m0_ar;
    assign s_ar_valid = sel ? m1_ar_valid : m0_ar_valid;
    assign s_aw       = sel ? m1_aw : m0_aw;
    assign s_aw_valid = sel ? m1_aw_valid : m0_aw_valid;
    assign s_w        = sel ? m1_w : m0_w;
    assign s_w_valid  = sel ? m1_w_valid : m0_w_valid;

    assign m0_ar_ready = ~sel & s_ar_ready;
    assign m1_ar_ready = sel & s_ar_ready;
    assign m0_aw_ready = ~sel & s_aw_ready;
    assign m1_aw_ready = sel & s_aw_ready;
    assign m0_w_ready  = ~sel & s_w_ready;
    assign m1_w_ready  = sel & s_w_ready;

    // responses go only to the granted master
    assign m0_r       = s_r;
    assign m1_r       = s_r;
    assign m0_r_valid = s_r_valid & ~grant;
    assign m1_r_valid = s_r_valid & grant;
    assign s_r_ready  = grant ? m1_r_ready : m0_r_ready;

    assign m0_b       = s_b;
    assign m1_b       = s_b;
    assign m0_b_valid = s_b_valid & ~grant;
    assign m1_b_valid = s_b_valid & grant;
    assign s_b_ready  = grant ? m1_b_ready : m0_b_ready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy  <= 1'b0;
            grant <= 1'b0;
        end else if (!busy) begin
            if (req0 || req1) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if ((s_r_valid && s_r_ready) || (s_b_valid && s_b_ready)) begin
            busy <= 1'b0;  // bus free next cycle
        end
    end

    resp_only_when_busy: assert property (@(posedge clk) disable iff (!reset)
        (s_r_valid || s_b_valid) |-> busy);

endmodule

`default_nettype wire

// ==== design/axi_master_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_master_port #(
    parameter logic [axi_pkg::axi_id_bits-1:0] master_id = '0
) (
    input  logic                              clk,
    input  logic                              reset,
    input  axi_pkg::cpu_req_t                 req,
    output logic [axi_pkg::axi_data_bits-1:0] rdata,
    output logic                              stall,
    output axi_pkg::axi_ar_t                  ar,
    output logic                              ar_valid,
    input  logic                              ar_ready,
    output axi_pkg::axi_ar_t                  aw,
    output logic                              aw_valid,
    input  logic                              aw_ready,
    output axi_pkg::axi_w_t                   w,
    output logic                              w_valid,
    input  logic                              w_ready,
    input  axi_pkg::axi_r_t                   r,
    input  logic                              r_valid,
    output logic                              r_ready,
    input  axi_pkg::axi_b_t                   b,
    input  logic                              b_valid,
    output logic                              b_ready
);

    typedef enum logic [2:0] {
        idle,
        read_address,
        read_data,
        write_address,
        write_data,
        write_response
    } state_t;

    state_t state, next_state;
    logic [axi_pkg::axi_data_bits-1:0] data_buf;
    logic resp_done;  // write ended last cycle, old request still on req
    logic r_fire;
    logic b_fire;

    assign r_fire = r_valid & r_ready;
    assign b_fire = b_valid & b_ready;

    assign ar = '{id: master_id, addr: req.addr, len: axi_pkg::axi_len_one,
                  size: axi_pkg::axi_size_word, burst: axi_pkg::axi_burst_inc};
    assign aw = ar;
    assign w  = '{data: req.wdata, strb: req.strb, last: 1'b1};

    assign rdata = r_fire ? r.data : data_buf;  // bypass in the handshake cycle

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            data_buf <= '0;
        end else if (r_fire) begin
            data_buf <= r.data;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= idle;
            resp_done <= 1'b0;
        end else begin
            state     <= next_state;
            resp_done <= b_fire;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (resp_done)
                    next_state = idle;
                else if (ar_valid && ar_ready)
                    next_state = read_data;
                else if (ar_valid)
                    next_state = read_address;
                else if (aw_valid && aw_ready)
                    next_state = write_data;
                else if (aw_valid)
                    next_state = write_address;
            end
            read_address:   if (ar_ready) next_state = read_data;
            read_data:      if (r_fire && r.last) next_state = idle;
            write_address:  if (aw_ready) next_state = write_data;
            write_data:     if (w_ready) next_state = write_response;  // wlast always set
            write_response: if (b_fire) next_state = idle;
            default:        next_state = idle;
        endcase
    end

    always_comb begin
        stall    = 1'b0;
        ar_valid = 1'b0;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        r_ready  = 1'b0;
        b_ready  = 1'b0;
        case (state)
            idle: begin
                stall    = (req.read | req.write) & ~resp_done;
                ar_valid = req.read & ~resp_done;
                aw_valid = req.write & ~resp_done;
            end
            read_address: begin
                stall    = 1'b1;
                ar_valid = 1'b1;
            end
            read_data: begin
                stall   = ~r_valid;  // released with the R handshake
                r_ready = 1'b1;
            end
            write_address: begin
                stall    = 1'b1;
                aw_valid = 1'b1;
            end
            write_data: begin
                stall   = 1'b1;
                w_valid = 1'b1;
            end
            write_response: begin
                stall   = 1'b1;
                b_ready = 1'b1;
            end
            default: stall = 1'b0;
        endcase
    end

    // cpu holds req while stalled, so AR and its payload stay put until taken
    ar_hold: assert property (@(posedge clk) disable iff (!reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

`default_nettype wire

// ==== design/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    localparam int axi_addr_bits  = 32;
    localparam int axi_data_bits  = 32;
    localparam int axi_strb_bits  = axi_data_bits / 8;  // one bit per byte
    localparam int axi_id_bits    = 4;
    localparam int axi_len_bits   = 4;
    localparam int axi_size_bits  = 3;
    localparam int axi_burst_bits = 2;
    localparam int axi_resp_bits  = 2;

    // len holds beats minus one
    localparam logic [axi_len_bits-1:0]   axi_len_one   = 4'd0;
    localparam logic [axi_size_bits-1:0]  axi_size_word = 3'b010;  // 4 bytes
    localparam logic [axi_burst_bits-1:0] axi_burst_inc = 2'b01;
    localparam logic [axi_resp_bits-1:0]  axi_resp_okay = 2'b00;

    // shared by AR and AW
    typedef struct packed {
        logic [axi_id_bits-1:0]    id;
        logic [axi_addr_bits-1:0]  addr;
        logic [axi_len_bits-1:0]   len;
        logic [axi_size_bits-1:0]  size;
        logic [axi_burst_bits-1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        logic [axi_data_bits-1:0] data;
        logic [axi_strb_bits-1:0] strb;
        logic                     last;
    } axi_w_t;

    typedef struct packed {
        logic [axi_id_bits-1:0]   id;
        logic [axi_data_bits-1:0] data;
        logic [axi_resp_bits-1:0] resp;
        logic                     last;
    } axi_r_t;

    typedef struct packed {
        logic [axi_id_bits-1:0]   id;
        logic [axi_resp_bits-1:0] resp;
    } axi_b_t;

    // read and write are never both set
    typedef struct packed {
        logic                     read;
        logic                     write;
        logic [axi_strb_bits-1:0] strb;
        logic [axi_addr_bits-1:0] addr;
        logic [axi_data_bits-1:0] wdata;
    } cpu_req_t;

endpackage

`default_nettype wire

// ==== design/axi_sram_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_sram_slave #(
    parameter int depth = 256
) (
    input  logic             clk,
    input  logic             reset,
    input  axi_pkg::axi_ar_t s_ar,
    input  logic             s_ar_valid,
    output logic             s_ar_ready,
    input  axi_pkg::axi_ar_t s_aw,
    input  logic             s_aw_valid,
    output logic             s_aw_ready,
    input  axi_pkg::axi_w_t  s_w,
    input  logic             s_w_valid,
    output logic             s_w_ready,
    output axi_pkg::axi_r_t  s_r,
    output logic             s_r_valid,
    input  logic             s_r_ready,
    output axi_pkg::axi_b_t  s_b,
    output logic             s_b_valid,
    input  logic             s_b_ready
);

    localparam int idx_bits = $clog2(depth);

    typedef enum logic [1:0] {
        idle,
        read_resp,
        write_data,
        write_resp
    } state_t;

    state_t state;
    logic [axi_pkg::axi_data_bits-1:0] mem [depth];
    logic [idx_bits-1:0] idx;  // write target
    logic [axi_pkg::axi_id_bits-1:0] id_q;
    logic [axi_pkg::axi_data_bits-1:0] rdata_q;
    logic ar_fire;
    logic aw_fire;
    logic w_fire;

    // word address modulo depth
    function automatic logic [idx_bits-1:0] word_index(
        input logic [axi_pkg::axi_addr_bits-1:0] addr
    );
        return idx_bits'((addr >> 2) % depth);
    endfunction

    assign s_ar_ready = (state == idle);
    assign s_aw_ready = (state == idle);
    assign s_w_ready  = (state == write_data);
    assign s_r_valid  = (state == read_resp);
    assign s_b_valid  = (state == write_resp);

    assign ar_fire = s_ar_valid & s_ar_ready;
    assign aw_fire = s_aw_valid & s_aw_ready;
    assign w_fire  = s_w_valid & s_w_ready;

    assign s_r = '{id: id_q, data: rdata_q, resp: axi_pkg::axi_resp_okay, last: 1'b1};
    assign s_b = '{id: id_q, resp: axi_pkg::axi_resp_okay};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (ar_fire)
                        state <= read_resp;
                    else if (aw_fire)
                        state <= write_data;
                end
                read_resp:  if (s_r_ready) state <= idle;
                write_data: if (w_fire) state <= write_resp;
                write_resp: if (s_b_ready) state <= idle;
                default:    state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q    <= s_ar.id;
            rdata_q <= mem[word_index(s_ar.addr)];
        end else if (aw_fire) begin
            id_q <= s_aw.id;
            idx  <= word_index(s_aw.addr);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < depth; i++)
                mem[i] <= '0;
        end else if (w_fire) begin
            for (int i = 0; i < axi_pkg::axi_strb_bits; i++) begin
                if (s_w.strb[i])
                    mem[idx][8*i +: 8] <= s_w.data[8*i +: 8];
            end
        end
    end

    // only one master is routed at a time
    no_dual_addr: assert property (@(posedge clk) disable iff (!reset)
        !(ar_fire && aw_fire));

endmodule

`default_nettype wire

// ==== design/cpu_mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_mem_subsystem #(
    parameter int mem_depth = 256
) (
    input  logic                              clk,
    input  logic                              reset,
    input  axi_pkg::cpu_req_t                 if_req,
    output logic [axi_pkg::axi_data_bits-1:0] if_rdata,
    output logic                              if_stall,
    input  axi_pkg::cpu_req_t                 ls_req,
    output logic [axi_pkg::axi_data_bits-1:0] ls_rdata,
    output logic                              ls_stall
);

    axi_pkg::axi_ar_t if_ar, if_aw, ls_ar, ls_aw, s_ar, s_aw;
    axi_pkg::axi_w_t  if_w, ls_w, s_w;
    axi_pkg::axi_r_t  if_r, ls_r, s_r;
    axi_pkg::axi_b_t  if_b, ls_b, s_b;

    logic if_ar_valid, if_ar_ready, if_aw_valid, if_aw_ready, if_w_valid, if_w_ready;
    logic if_r_valid, if_r_ready, if_b_valid, if_b_ready;
    logic ls_ar_valid, ls_ar_ready, ls_aw_valid, ls_aw_ready, ls_w_valid, ls_w_ready;
    logic ls_r_valid, ls_r_ready, ls_b_valid, ls_b_ready;
    logic s_ar_valid, s_ar_ready, s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
    logic s_r_valid, s_r_ready, s_b_valid, s_b_ready;

    // instruction fetch
    axi_master_port #(.master_id(4'd0)) if_port (
        .clk(clk), .reset(reset), .req(if_req), .rdata(if_rdata), .stall(if_stall),
        .ar(if_ar), .ar_valid(if_ar_valid), .ar_ready(if_ar_ready),
        .aw(if_aw), .aw_valid(if_aw_valid), .aw_ready(if_aw_ready),
        .w(if_w), .w_valid(if_w_valid), .w_ready(if_w_ready),
        .r(if_r), .r_valid(if_r_valid), .r_ready(if_r_ready),
        .b(if_b), .b_valid(if_b_valid), .b_ready(if_b_ready)
    );

    // load/store
    axi_master_port #(.master_id(4'd1)) ls_port (
        .clk(clk), .reset(reset), .req(ls_req), .rdata(ls_rdata), .stall(ls_stall),
        .ar(ls_ar), .ar_valid(ls_ar_valid), .ar_ready(ls_ar_ready),
        .aw(ls_aw), .aw_valid(ls_aw_valid), .aw_ready(ls_aw_ready),
        .w(ls_w), .w_valid(ls_w_valid), .w_ready(ls_w_ready),
        .r(ls_r), .r_valid(ls_r_valid), .r_ready(ls_r_ready),
        .b(ls_b), .b_valid(ls_b_valid), .b_ready(ls_b_ready)
    );

    axi_bus_arbiter arbiter (
        .clk(clk), .reset(reset),
        .m0_ar(if_ar), .m0_ar_valid(if_ar_valid), .m0_ar_ready(if_ar_ready),
        .m0_aw(if_aw), .m0_aw_valid(if_aw_valid), .m0_aw_ready(if_aw_ready),
        .m0_w(if_w), .m0_w_valid(if_w_valid), .m0_w_ready(if_w_ready),
        .m0_r(if_r), .m0_r_valid(if_r_valid), .m0_r_ready(if_r_ready),
        .m0_b(if_b), .m0_b_valid(if_b_valid), .m0_b_ready(if_b_ready),
        .m1_ar(ls_ar), .m1_ar_valid(ls_ar_valid), .m1_ar_ready(ls_ar_ready),
        .m1_aw(ls_aw), .m1_aw_valid(ls_aw_valid), .m1_aw_ready(ls_aw_ready),
        .m1_w(ls_w), .m1_w_valid(ls_w_valid), .m1_w_ready(ls_w_ready),
        .m1_r(ls_r), .m1_r_valid(ls_r_valid), .m1_r_ready(ls_r_ready),
        .m1_b(ls_b), .m1_b_valid(ls_b_valid), .m1_b_ready(ls_b_ready),
        .s_ar(s_ar), .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready),
        .s_aw(s_aw), .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready),
        .s_w(s_w), .s_w_valid(s_w_valid), .s_w_ready(s_w_ready),
        .s_r(s_r), .s_r_valid(s_r_valid), .s_r_ready(s_r_ready),
        .s_b(s_b), .s_b_valid(s_b_valid), .s_b_ready(s_b_ready)
    );

    axi_sram_slave #(.depth(mem_depth)) sram (
        .clk(clk), .reset(reset),
        .s_ar(s_ar), .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready),
        .s_aw(s_aw), .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready),
        .s_w(s_w), .s_w_valid(s_w_valid), .s_w_ready(s_w_ready),
        .s_r(s_r), .s_r_valid(s_r_valid), .s_r_ready(s_r_ready),
        .s_b(s_b), .s_b_valid(s_b_valid), .s_b_ready(s_b_ready)
    );

endmodule

`default_nettype wire

// ==== flist.f ====
design/axi_pkg.sv
design/axi_master_port.sv
design/axi_bus_arbiter.sv
design/axi_sram_slave.sv
design/cpu_mem_subsystem.sv
verification/tb_cpu_mem_subsystem.sv

// ==== verification/tb_cpu_mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_mem_subsystem;

    localparam int depth = 256;
    localparam int reset_cycles = 5;
    localparam int num_requests = 51;  // 2 + 3 + 2 + 4 + 40
    localparam int timeout_cycles = reset_cycles + num_requests * 10 + 20;

    logic clk;
    logic reset;
    axi_pkg::cpu_req_t if_req;
    axi_pkg::cpu_req_t ls_req;
    logic [31:0] if_rdata;
    logic [31:0] ls_rdata;
    logic if_stall;
    logic ls_stall;

    logic [31:0] ref_mem [depth];  // reference memory
    logic [31:0] rng_state;
    int error_count;
    int check_count;
    int tests_run;
    int failing_tests;
    int cycle_count;

    cpu_mem_subsystem #(.mem_depth(depth)) dut0 (
        .clk(clk), .reset(reset),
        .if_req(if_req), .if_rdata(if_rdata), .if_stall(if_stall),
        .ls_req(ls_req), .ls_rdata(ls_rdata), .ls_stall(ls_stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // word address modulo depth
    function automatic int ref_index(input logic [31:0] addr);
        return int'((addr >> 2) % depth);
    endfunction

    function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
        int k;
        k = ref_index(addr);
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                ref_mem[k][8*i +: 8] = data[8*i +: 8];
        end
    endfunction

    function automatic axi_pkg::cpu_req_t read_req(input logic [31:0] addr);
        axi_pkg::cpu_req_t rq;
        rq = '0;
        rq.read = 1'b1;
        rq.addr = addr;
        return rq;
    endfunction

    function automatic axi_pkg::cpu_req_t write_req(input logic [31:0] addr,
                                                    input logic [31:0] data,
                                                    input logic [3:0] strb);
        axi_pkg::cpu_req_t rq;
        rq = '0;
        rq.write = 1'b1;
        rq.strb  = strb;
        rq.addr  = addr;
        rq.wdata = data;
        return rq;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failing_tests++;
            $display("%s: %0d mismatches", name, error_count - errors_before);
        end
    endtask

    // one request on one port, held until stall drops
    task automatic run_request(input bit on_ls, input axi_pkg::cpu_req_t rq,
                               output logic [31:0] rd);
        @(posedge clk);
        if (on_ls)
            ls_req <= rq;
        else
            if_req <= rq;
        do
            @(negedge clk);
        while (on_ls ? ls_stall : if_stall);
        rd = on_ls ? ls_rdata : if_rdata;  // valid in the handshake cycle
        @(posedge clk);
        if (on_ls)
            ls_req <= '0;
        else
            if_req <= '0;
    endtask

    task automatic write_word(input bit on_ls, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] unused;
        run_request(on_ls, write_req(addr, data, strb), unused);
        ref_write(addr, data, strb);
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        check_value("if_stall", 32'(if_stall), 32'h0);
        check_value("ls_stall", 32'(ls_stall), 32'h0);
        check_value("if_rdata", if_rdata, 32'h0);
        check_value("ls_rdata", ls_rdata, 32'h0);
        finish_test("reset state", errors_before);
    endtask

    task automatic full_word_round_trip();
        int errors_before;
        logic [31:0] rd;
        errors_before = error_count;
        write_word(1'b1, 32'h0000_0040, 32'hdead_beef, 4'hf);
        run_request(1'b1, read_req(32'h0000_0040), rd);
        check_value("ls_rdata", rd, ref_mem[ref_index(32'h0000_0040)]);
        repeat (3) begin  // port idle, data held
            @(negedge clk);
            check_value("ls_rdata", ls_rdata, ref_mem[ref_index(32'h0000_0040)]);
            check_value("ls_stall", 32'(ls_stall), 32'h0);
        end
        finish_test("full word round trip", errors_before);
    endtask

    task automatic partial_strobe_merge();
        int errors_before;
        logic [31:0] rd;
        errors_before = error_count;
        write_word(1'b1, 32'h0000_0080, 32'h1122_3344, 4'hf);
        write_word(1'b1, 32'h0000_0480, 32'haabb_ccdd, 4'b0101);  // aliases 0x80
        run_request(1'b1, read_req(32'h0000_0080), rd);
        check_value("ls_rdata", rd, ref_mem[ref_index(32'h0000_0080)]);
        finish_test("partial strobe merge", errors_before);
    endtask

    task automatic cross_port_visibility();
        int errors_before;
        logic [31:0] rd;
        errors_before = error_count;
        write_word(1'b1, 32'h0000_0100, 32'hcafe_f00d, 4'hf);
        run_request(1'b0, read_req(32'h0000_0100), rd);
        check_value("if_rdata", rd, ref_mem[ref_index(32'h0000_0100)]);
        finish_test("cross port visibility", errors_before);
    endtask

    task automatic simultaneous_reads();
        int errors_before;
        logic [31:0] rd_if;
        logic [31:0] rd_ls;
        errors_before = error_count;
        write_word(1'b1, 32'h0000_0200, 32'h0123_4567, 4'hf);
        write_word(1'b1, 32'h0000_03f4, 32'h89ab_cdef, 4'hf);
        fork
            run_request(1'b0, read_req(32'h0000_0200), rd_if);
            run_request(1'b1, read_req(32'h0000_03f4), rd_ls);
        join
        check_value("if_rdata", rd_if, ref_mem[ref_index(32'h0000_0200)]);
        check_value("ls_rdata", rd_ls, ref_mem[ref_index(32'h0000_03f4)]);
        finish_test("simultaneous reads", errors_before);
    endtask

    task automatic random_mix();
        int errors_before;
        logic [31:0] addr_if, addr_ls, data_if, data_ls;
        logic [31:0] exp_if, exp_ls, rd_if, rd_ls, ctl_if, ctl_ls;
        errors_before = error_count;
        for (int n = 0; n < 20; n++) begin
            // small word range with random high bits for aliasing
            addr_if = next_random() & 32'hffff_f03c;
            addr_ls = next_random() & 32'hffff_f03c;
            if (ref_index(addr_if) == ref_index(addr_ls))
                addr_ls = addr_ls ^ 32'h4;
            data_if = next_random();
            data_ls = next_random();
            ctl_if  = next_random();
            ctl_ls  = next_random();
            exp_if  = ref_mem[ref_index(addr_if)];
            exp_ls  = ref_mem[ref_index(addr_ls)];
            fork
                if (ctl_if[0])
                    run_request(1'b0, write_req(addr_if, data_if, ctl_if[7:4]), rd_if);
                else
                    run_request(1'b0, read_req(addr_if), rd_if);
                if (ctl_ls[0])
                    run_request(1'b1, write_req(addr_ls, data_ls, ctl_ls[7:4]), rd_ls);
                else
                    run_request(1'b1, read_req(addr_ls), rd_ls);
            join
            if (ctl_if[0])
                ref_write(addr_if, data_if, ctl_if[7:4]);
            else
                check_value("if_rdata", rd_if, exp_if);
            if (ctl_ls[0])
                ref_write(addr_ls, data_ls, ctl_ls[7:4]);
            else
                check_value("ls_rdata", rd_ls, exp_ls);
        end
        finish_test("random mix", errors_before);
    endtask

    initial begin
        reset = 1'b0;
        if_req = '0;
        ls_req = '0;
        rng_state = 32'd12;
        error_count = 0;
        check_count = 0;
        tests_run = 0;
        failing_tests = 0;
        for (int i = 0; i < depth; i++)
            ref_mem[i] = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b1;

        check_reset_state();
        full_word_round_trip();
        partial_strobe_merge();
        cross_port_visibility();
        simultaneous_reads();
        random_mix();

        $display("tests run %0d, failing %0d, checks %0d, errors %0d",
                 tests_run, failing_tests, check_count, error_count);
        if (error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
